// File: mmu_config.svh
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// crmd fields
`define CSR_CRMD_PLV    1:0
`define CSR_CRMD_DA     3
`define CSR_CRMD_PG     4
`define CSR_CRMD_DATF   6:5
`define CSR_CRMD_WMASK  32'h0000_007f
`define CRMD_RESET      32'h0000_0008

// asid field
`define CSR_ASID_ASID   9:0

// direct map window fields, bits 0 and 3 enable plv0 and plv3
`define CSR_DMW_MAT     5:4
`define CSR_DMW_PSEG    27:25
`define CSR_DMW_VSEG    31:29
`define CSR_DMW_WMASK   32'hfe00_0039

// csr numbers
`define CSR_NUM_CRMD    14'h000
`define CSR_NUM_ASID    14'h018
`define CSR_NUM_DMW0    14'h180
`define CSR_NUM_DMW1    14'h181

// tlb geometry
`define TLB_ENTRIES     16
`define TLB_IDX_W       4

// page size exponents
`define PS_4K           6'd12
`define PS_2M           6'd21

`endif

// File: mmu_pkg.sv
`include "mmu_config.svh"

package mmu_pkg;

    // addresses
    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;

    // page numbers, vppn covers va[31:13]
    typedef logic [18:0] vppn_t;
    typedef logic [19:0] ppn_t;

    // page attributes
    typedef logic [9:0]  asid_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [5:0]  ps_t;

    // csr access
    typedef logic [13:0] csr_num_t;
    typedef logic [31:0] csr_data_t;

    // tlb maintenance
    typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;
    typedef logic [4:0]  invtlb_op_t;

endpackage

// File: tlb_search_if.sv
interface tlb_search_if;
    import mmu_pkg::*;

    // request side
    vppn_t vppn;
    logic  va_bit12;
    asid_t asid;

    // lookup result, valid in the same cycle
    logic  found;
    ppn_t  ppn;
    ps_t   ps;
    plv_t  plv;
    mat_t  mat;
    logic  d;
    logic  v;

    modport addr_trans (
        output vppn, va_bit12, asid,
        input  found, ppn, ps, plv, mat, d, v
    );

    modport tlb (
        input  vppn, va_bit12, asid,
        output found, ppn, ps, plv, mat, d, v
    );

endinterface

// File: tlb_write_if.sv
interface tlb_write_if;
    import mmu_pkg::*;

    logic     we;
    tlb_idx_t idx;
    vppn_t    vppn;
    ps_t      ps;
    logic     g;
    asid_t    asid;
    logic     e;

    // even page
    ppn_t     ppn0;
    plv_t     plv0;
    mat_t     mat0;
    logic     d0;
    logic     v0;

    // odd page
    ppn_t     ppn1;
    plv_t     plv1;
    mat_t     mat1;
    logic     d1;
    logic     v1;

    modport src (
        output we, idx, vppn, ps, g, asid, e,
        output ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1
    );

    modport tlb (
        input  we, idx, vppn, ps, g, asid, e,
        input  ppn0, plv0, mat0, d0, v0, ppn1, plv1, mat1, d1, v1
    );
endinterface

// File: mmu_csr.sv
`include "mmu_config.svh"

module mmu_csr (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                csr_we,
    input  mmu_pkg::csr_num_t   csr_num,
    input  mmu_pkg::csr_data_t  csr_wdata,
    output mmu_pkg::csr_data_t  crmd,
    output mmu_pkg::asid_t      asid,
    output mmu_pkg::csr_data_t  dmw0,
    output mmu_pkg::csr_data_t  dmw1
);

    // reserved bits read as zero, so they are dropped on write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd <= `CRMD_RESET;
            asid <= '0;
            dmw0 <= '0;
            dmw1 <= '0;
        end else if (csr_we) begin
            case (csr_num)
                `CSR_NUM_CRMD: begin
                    crmd <= csr_wdata & `CSR_CRMD_WMASK;
                end
                `CSR_NUM_ASID: begin
                    asid <= csr_wdata[`CSR_ASID_ASID];
                end
                `CSR_NUM_DMW0: begin
                    dmw0 <= csr_wdata & `CSR_DMW_WMASK;
                end
                `CSR_NUM_DMW1: begin
                    dmw1 <= csr_wdata & `CSR_DMW_WMASK;
                end
                default: begin
                    // unknown csr, write dropped
                end
            endcase
        end
    end

endmodule

// File: tlb.sv
`include "mmu_config.svh"

module tlb (
    input  logic                 clk,
    input  logic                 rst_n,
    tlb_search_if.tlb            search,
    tlb_write_if.tlb             wr,
    input  logic                 invtlb_valid,
    input  mmu_pkg::invtlb_op_t  invtlb_op,
    input  mmu_pkg::asid_t       invtlb_asid,
    input  mmu_pkg::vaddr_t      invtlb_va
);
    import mmu_pkg::*;

    // entry fields, index 0 is the even page and 1 the odd page
    logic   tlb_e    [`TLB_ENTRIES];
    logic   tlb_g    [`TLB_ENTRIES];
    asid_t  tlb_asid [`TLB_ENTRIES];
    vppn_t  tlb_vppn [`TLB_ENTRIES];
    ps_t    tlb_ps   [`TLB_ENTRIES];
    ppn_t   tlb_ppn  [`TLB_ENTRIES][2];
    plv_t   tlb_plv  [`TLB_ENTRIES][2];
    mat_t   tlb_mat  [`TLB_ENTRIES][2];
    logic   tlb_d    [`TLB_ENTRIES][2];
    logic   tlb_v    [`TLB_ENTRIES][2];

    logic [`TLB_ENTRIES-1:0] match;
    logic [`TLB_ENTRIES-1:0] inv_asid_eq;
    logic [`TLB_ENTRIES-1:0] inv_va_eq;
    logic [`TLB_ENTRIES-1:0] inv_match;
    vppn_t                   inv_vppn;
    tlb_idx_t                hit_idx;
    logic                    hit_odd;

    // 2 MB pages only compare the upper ten vppn bits
    function automatic logic vppn_eq(input ps_t ps, input vppn_t a, input vppn_t b);
        if (ps == `PS_2M) begin
            return a[18:9] == b[18:9];
        end
        return a == b;
    endfunction

    // associative search
    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            match[i] = tlb_e[i] && (tlb_g[i] || tlb_asid[i] == search.asid)
                       && vppn_eq(tlb_ps[i], tlb_vppn[i], search.vppn);
        end
    end

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (match[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign hit_odd = (tlb_ps[hit_idx] == `PS_2M) ? search.vppn[8] : search.va_bit12;

    assign search.found = |match;
    assign search.ppn   = search.found ? tlb_ppn[hit_idx][hit_odd] : '0;
    assign search.ps    = search.found ? tlb_ps[hit_idx] : '0;
    assign search.plv   = search.found ? tlb_plv[hit_idx][hit_odd] : '0;
    assign search.mat   = search.found ? tlb_mat[hit_idx][hit_odd] : '0;
    assign search.d     = search.found && tlb_d[hit_idx][hit_odd];
    assign search.v     = search.found && tlb_v[hit_idx][hit_odd];

    // invtlb entry selection
    assign inv_vppn = invtlb_va[31:13];

    always_comb begin
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            inv_asid_eq[i] = tlb_asid[i] == invtlb_asid;
            inv_va_eq[i]   = vppn_eq(tlb_ps[i], tlb_vppn[i], inv_vppn);
            case (invtlb_op)
                5'd0, 5'd1: inv_match[i] = 1'b1;
                5'd2:       inv_match[i] = tlb_g[i];
                5'd3:       inv_match[i] = !tlb_g[i];
                5'd4:       inv_match[i] = !tlb_g[i] && inv_asid_eq[i];
                5'd5:       inv_match[i] = !tlb_g[i] && inv_asid_eq[i] && inv_va_eq[i];
                5'd6:       inv_match[i] = (tlb_g[i] || inv_asid_eq[i]) && inv_va_eq[i];
                default:    inv_match[i] = 1'b0;
            endcase
        end
    end

    // valid bits, a write in the same cycle lands after the invalidate
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `TLB_ENTRIES; i++) begin
                tlb_e[i] <= 1'b0;
            end
        end else begin
            if (invtlb_valid) begin
                for (int i = 0; i < `TLB_ENTRIES; i++) begin
                    if (inv_match[i]) begin
                        tlb_e[i] <= 1'b0;
                    end
                end
            end
            if (wr.we) begin
                tlb_e[wr.idx] <= wr.e;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.we) begin
            tlb_g[wr.idx]      <= wr.g;
            tlb_asid[wr.idx]   <= wr.asid;
            tlb_vppn[wr.idx]   <= wr.vppn;
            tlb_ps[wr.idx]     <= wr.ps;
            tlb_ppn[wr.idx][0] <= wr.ppn0;
            tlb_plv[wr.idx][0] <= wr.plv0;
            tlb_mat[wr.idx][0] <= wr.mat0;
            tlb_d[wr.idx][0]   <= wr.d0;
            tlb_v[wr.idx][0]   <= wr.v0;
            tlb_ppn[wr.idx][1] <= wr.ppn1;
            tlb_plv[wr.idx][1] <= wr.plv1;
            tlb_mat[wr.idx][1] <= wr.mat1;
            tlb_d[wr.idx][1]   <= wr.d1;
            tlb_v[wr.idx][1]   <= wr.v1;
        end
    end

    // software must never leave overlapping entries
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n) $onehot0(match)
    ) else $error("tlb: multiple entries hit one search");

endmodule

// File: addr_trans.sv
`include "mmu_config.svh"

module addr_trans (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  mmu_pkg::vaddr_t     req_va,
    input  logic                req_store,
    input  mmu_pkg::csr_data_t  crmd,
    input  mmu_pkg::asid_t      asid,
    input  mmu_pkg::csr_data_t  dmw0,
    input  mmu_pkg::csr_data_t  dmw1,
    tlb_search_if.addr_trans    search,
    output logic                resp_valid,
    output mmu_pkg::paddr_t     resp_pa,
    output mmu_pkg::mat_t       resp_mat,
    output logic                page_fault,
    output logic                page_invalid,
    output logic                ppi_except,
    output logic                page_clean
);
    import mmu_pkg::*;

    plv_t   cur_plv;
    logic   direct_trans;
    logic   dmw0_hit;
    logic   dmw1_hit;
    logic   tlb_map;
    paddr_t tlb_pa;
    paddr_t pa;
    mat_t   mat;

    assign cur_plv      = crmd[`CSR_CRMD_PLV];
    assign direct_trans = crmd[`CSR_CRMD_DA] && !crmd[`CSR_CRMD_PG];

    // window enable bits are indexed by the current plv
    assign dmw0_hit = !direct_trans && dmw0[cur_plv]
                      && dmw0[`CSR_DMW_VSEG] == req_va[31:29];
    assign dmw1_hit = !direct_trans && !dmw0_hit && dmw1[cur_plv]
                      && dmw1[`CSR_DMW_VSEG] == req_va[31:29];
    assign tlb_map  = !direct_trans && !dmw0_hit && !dmw1_hit;

    assign search.vppn     = req_va[31:13];
    assign search.va_bit12 = req_va[12];
    assign search.asid     = asid;

    assign tlb_pa = (search.ps == `PS_2M) ? {search.ppn[19:9], req_va[20:0]}
                                          : {search.ppn, req_va[11:0]};

    always_comb begin
        if (direct_trans) begin
            pa  = req_va;
            mat = crmd[`CSR_CRMD_DATF];
        end else if (dmw0_hit) begin
            pa  = {dmw0[`CSR_DMW_PSEG], req_va[28:0]};
            mat = dmw0[`CSR_DMW_MAT];
        end else if (dmw1_hit) begin
            pa  = {dmw1[`CSR_DMW_PSEG], req_va[28:0]};
            mat = dmw1[`CSR_DMW_MAT];
        end else begin
            pa  = tlb_pa;
            mat = search.mat;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= req_valid;
        end
    end

    // dirty check applies to stores only
    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp_pa      <= pa;
            resp_mat     <= mat;
            page_fault   <= tlb_map && !search.found;
            page_invalid <= tlb_map && search.found && !search.v;
            ppi_except   <= tlb_map && search.found && search.v && cur_plv > search.plv;
            page_clean   <= tlb_map && search.found && search.v && req_store && !search.d;
        end
    end

    // tlb_pa only handles 4 KB and 2 MB pages
    a_known_page_size: assert property (
        @(posedge clk) disable iff (!rst_n)
        req_valid && tlb_map && search.found
            |-> (search.ps == `PS_4K || search.ps == `PS_2M)
    ) else $error("addr_trans: tlb hit with unsupported page size");

endmodule

// File: mmu_top.sv
module mmu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 csr_we,
    input  mmu_pkg::csr_num_t    csr_num,
    input  mmu_pkg::csr_data_t   csr_wdata,
    input  logic                 tlb_we,
    input  mmu_pkg::tlb_idx_t    tlb_idx,
    input  mmu_pkg::vppn_t       tlb_vppn,
    input  mmu_pkg::ps_t         tlb_ps,
    input  logic                 tlb_g,
    input  mmu_pkg::asid_t       tlb_asid,
    input  logic                 tlb_e,
    input  mmu_pkg::ppn_t        tlb_ppn0,
    input  mmu_pkg::plv_t        tlb_plv0,
    input  mmu_pkg::mat_t        tlb_mat0,
    input  logic                 tlb_d0,
    input  logic                 tlb_v0,
    input  mmu_pkg::ppn_t        tlb_ppn1,
    input  mmu_pkg::plv_t        tlb_plv1,
    input  mmu_pkg::mat_t        tlb_mat1,
    input  logic                 tlb_d1,
    input  logic                 tlb_v1,
    input  logic                 invtlb_valid,
    input  mmu_pkg::invtlb_op_t  invtlb_op,
    input  mmu_pkg::asid_t       invtlb_asid,
    input  mmu_pkg::vaddr_t      invtlb_va,
    input  logic                 req_valid,
    input  mmu_pkg::vaddr_t      req_va,
    input  logic                 req_store,
    output logic                 resp_valid,
    output mmu_pkg::paddr_t      resp_pa,
    output mmu_pkg::mat_t        resp_mat,
    output logic                 page_fault,
    output logic                 page_invalid,
    output logic                 ppi_except,
    output logic                 page_clean
);
    import mmu_pkg::*;

    csr_data_t crmd;
    asid_t     asid;
    csr_data_t dmw0;
    csr_data_t dmw1;

    tlb_search_if search_if ();
    tlb_write_if  wr_if ();

    // tlb write port from the top level pins
    assign wr_if.we   = tlb_we;
    assign wr_if.idx  = tlb_idx;
    assign wr_if.vppn = tlb_vppn;
    assign wr_if.ps   = tlb_ps;
    assign wr_if.g    = tlb_g;
    assign wr_if.asid = tlb_asid;
    assign wr_if.e    = tlb_e;
    assign wr_if.ppn0 = tlb_ppn0;
    assign wr_if.plv0 = tlb_plv0;
    assign wr_if.mat0 = tlb_mat0;
    assign wr_if.d0   = tlb_d0;
    assign wr_if.v0   = tlb_v0;
    assign wr_if.ppn1 = tlb_ppn1;
    assign wr_if.plv1 = tlb_plv1;
    assign wr_if.mat1 = tlb_mat1;
    assign wr_if.d1   = tlb_d1;
    assign wr_if.v1   = tlb_v1;

    mmu_csr i_csr (
        .clk       (clk),
        .rst_n     (rst_n),
        .csr_we    (csr_we),
        .csr_num   (csr_num),
        .csr_wdata (csr_wdata),
        .crmd      (crmd),
        .asid      (asid),
        .dmw0      (dmw0),
        .dmw1      (dmw1)
    );

    tlb i_tlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .search       (search_if.tlb),
        .wr           (wr_if.tlb),
        .invtlb_valid (invtlb_valid),
        .invtlb_op    (invtlb_op),
        .invtlb_asid  (invtlb_asid),
        .invtlb_va    (invtlb_va)
    );

    addr_trans i_addr_trans (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_va       (req_va),
        .req_store    (req_store),
        .crmd         (crmd),
        .asid         (asid),
        .dmw0         (dmw0),
        .dmw1         (dmw1),
        .search       (search_if.addr_trans),
        .resp_valid   (resp_valid),
        .resp_pa      (resp_pa),
        .resp_mat     (resp_mat),
        .page_fault   (page_fault),
        .page_invalid (page_invalid),
        .ppi_except   (ppi_except),
        .page_clean   (page_clean)
    );

endmodule

// File: tb_mmu.sv
module tb_mmu;
    timeunit 1ns;
    timeprecision 1ps;

    import mmu_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       csr_we;
    csr_num_t   csr_num;
    csr_data_t  csr_wdata;
    logic       tlb_we;
    tlb_idx_t   tlb_idx;
    vppn_t      tlb_vppn;
    ps_t        tlb_ps;
    logic       tlb_g;
    asid_t      tlb_asid;
    logic       tlb_e;
    ppn_t       tlb_ppn0;
    plv_t       tlb_plv0;
    mat_t       tlb_mat0;
    logic       tlb_d0;
    logic       tlb_v0;
    ppn_t       tlb_ppn1;
    plv_t       tlb_plv1;
    mat_t       tlb_mat1;
    logic       tlb_d1;
    logic       tlb_v1;
    logic       invtlb_valid;
    invtlb_op_t invtlb_op;
    asid_t      invtlb_asid;
    vaddr_t     invtlb_va;
    logic       req_valid;
    vaddr_t     req_va;
    logic       req_store;
    logic       resp_valid;
    paddr_t     resp_pa;
    mat_t       resp_mat;
    logic       page_fault;
    logic       page_invalid;
    logic       ppi_except;
    logic       page_clean;

    // expected results, oldest request first
    string       name_q[$];
    logic [31:0] pa_q[$];
    logic [31:0] mat_q[$];
    logic [31:0] flags_q[$];
    int          wait_cycles;
    int          req_count;
    int          fd;

    mmu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error %s expected %h actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic init_inputs();
        rst_n        = 1'b0;
        csr_we       = 1'b0;
        csr_num      = '0;
        csr_wdata    = '0;
        tlb_we       = 1'b0;
        tlb_idx      = '0;
        tlb_vppn     = '0;
        tlb_ps       = '0;
        tlb_g        = 1'b0;
        tlb_asid     = '0;
        tlb_e        = 1'b0;
        tlb_ppn0     = '0;
        tlb_plv0     = '0;
        tlb_mat0     = '0;
        tlb_d0       = 1'b0;
        tlb_v0       = 1'b0;
        tlb_ppn1     = '0;
        tlb_plv1     = '0;
        tlb_mat1     = '0;
        tlb_d1       = 1'b0;
        tlb_v1       = 1'b0;
        invtlb_valid = 1'b0;
        invtlb_op    = '0;
        invtlb_asid  = '0;
        invtlb_va    = '0;
        req_valid    = 1'b0;
        req_va       = '0;
        req_store    = 1'b0;
    endtask

    // outputs registered at the last edge are stable here
    task automatic collect_response();
        string name;
        if (resp_valid) begin
            if (pa_q.size() == 0) begin
                $display("Test failures found");
                $fatal(1, "response arrived with no request outstanding");
            end
            name = name_q.pop_front();
            check_value({name, " pa"}, pa_q.pop_front(), resp_pa);
            check_value({name, " mat"}, mat_q.pop_front(), 32'(resp_mat));
            check_value({name, " flags"}, flags_q.pop_front(),
                        32'({page_fault, page_invalid, ppi_except, page_clean}));
            wait_cycles = 0;
        end else if (pa_q.size() != 0) begin
            wait_cycles++;
            if (wait_cycles >= 4) begin
                $display("Test failures found");
                $fatal(1, "no response within 4 cycles of a request");
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
        collect_response();
        csr_we       = 1'b0;
        tlb_we       = 1'b0;
        invtlb_valid = 1'b0;
        req_valid    = 1'b0;
    endtask

    initial begin
        logic [7:0]  kind;
        logic [31:0] f [16];
        int          code;
        int          want;
        int          ch;
        int          drain_left;
        bit          done;

        init_inputs();
        wait_cycles = 0;
        req_count = 0;
        fd = $fopen("mmu_golden.txt", "r");
        if (fd == 0) begin
            $display("Test failures found");
            $fatal(1, "cannot open mmu_golden.txt");
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else begin
                // a leading + keeps the record in the cycle before
                if (kind == "+") begin
                    code = $fscanf(fd, " %c", kind);
                end else begin
                    next_cycle();
                end
                want = 0;
                code = 0;
                case (kind)
                    "C": begin
                        code = $fscanf(fd, "%h %h", f[0], f[1]);
                        want = 2;
                        csr_we    = 1'b1;
                        csr_num   = f[0][13:0];
                        csr_wdata = f[1];
                    end
                    "T": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                       f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                        want = 16;
                        tlb_we   = 1'b1;
                        tlb_idx  = f[0][3:0];
                        tlb_vppn = f[1][18:0];
                        tlb_ps   = f[2][5:0];
                        tlb_g    = f[3][0];
                        tlb_asid = f[4][9:0];
                        tlb_e    = f[5][0];
                        tlb_ppn0 = f[6][19:0];
                        tlb_plv0 = f[7][1:0];
                        tlb_mat0 = f[8][1:0];
                        tlb_d0   = f[9][0];
                        tlb_v0   = f[10][0];
                        tlb_ppn1 = f[11][19:0];
                        tlb_plv1 = f[12][1:0];
                        tlb_mat1 = f[13][1:0];
                        tlb_d1   = f[14][0];
                        tlb_v1   = f[15][0];
                    end
                    "I": begin
                        code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
                        want = 3;
                        invtlb_valid = 1'b1;
                        invtlb_op    = f[0][4:0];
                        invtlb_asid  = f[1][9:0];
                        invtlb_va    = f[2];
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                        want = 8;
                        req_valid = 1'b1;
                        req_va    = f[0];
                        req_store = f[1][0];
                        name_q.push_back($sformatf("req%0d", req_count));
                        pa_q.push_back(f[2]);
                        mat_q.push_back(f[3]);
                        flags_q.push_back({28'b0, f[4][0], f[5][0], f[6][0], f[7][0]});
                        req_count++;
                    end
                    "N": begin
                        want = 0;
                    end
                    default: begin
                        $display("Test failures found");
                        $fatal(1, "unknown record kind in mmu_golden.txt");
                    end
                endcase
                if (code != want) begin
                    $display("Test failures found");
                    $fatal(1, "malformed record in mmu_golden.txt");
                end
            end
        end
        $fclose(fd);

        drain_left = 4;
        while (pa_q.size() != 0 && drain_left > 0) begin
            next_cycle();
            drain_left--;
        end
        if (pa_q.size() != 0) begin
            $display("Test failures found");
            $fatal(1, "responses still outstanding at the end of the run");
        end else begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

// File: mmu_golden.txt
# one record per cycle, all fields hex, a leading + puts a record in the cycle before
# C csr_num data   T idx vppn ps g asid e ppn0 plv0 mat0 d0 v0 ppn1 plv1 mat1 d1 v1
# I op asid va     R va store pa mat fault invalid ppi clean   N idle
R 12345678 0 12345678 0 0 0 0 0
R 9abcdef0 1 9abcdef0 0 0 0 0 0
C 000 00000028
R 00001000 0 00001000 1 0 0 0 0
C 000 00000048
R 8000abcd 0 8000abcd 2 0 0 0 0
# mapped mode, direct map windows
C 000 00000010
C 180 82000011
C 181 a0000021
R 80001234 0 20001234 1 0 0 0 0
R a0005678 1 00005678 2 0 0 0 0
C 000 00000013
R 80001234 0 00000234 0 1 0 0 0
C 180 82000019
C 181 80000029
R 80001234 0 20001234 1 0 0 0 0
C 180 00000000
R 80001234 0 00001234 2 0 0 0 0
# tlb pages, 4 KB and 2 MB
C 181 00000000
C 000 00000010
C 018 00000005
T 0 00200 0c 0 005 1 12345 0 1 1 1 23456 0 1 1 1
R 00400abc 0 12345abc 1 0 0 0 0
R 00401def 1 23456def 1 0 0 0 0
T 1 08000 15 1 3ff 1 40000 0 0 1 1 502ab 0 2 1 1
R 10012345 0 40012345 0 0 0 0 0
R 10234567 0 50234567 2 0 0 0 0
C 018 00000007
R 10012345 0 40012345 0 0 0 0 0
R 00400abc 0 00000abc 0 1 0 0 0
C 018 00000005
# exception flags
T 2 00300 0c 0 005 1 11111 0 1 1 0 22222 0 1 0 1
R 00600010 0 11111010 1 0 1 0 0
R 00601020 1 22222020 1 0 0 0 1
R 00601024 0 22222024 1 0 0 0 0
R 00800000 0 00000000 0 1 0 0 0
C 000 00000013
R 00601028 0 22222028 1 0 0 1 0
C 000 00000010
# invtlb
T 3 00380 0c 0 009 1 33333 0 1 1 1 33334 0 1 1 1
T 4 00500 0c 1 000 1 44444 0 3 1 1 44445 0 3 1 1
R 00a00020 0 44444020 3 0 0 0 0
I 07 005 00400000
R 00400abc 0 12345abc 1 0 0 0 0
I 06 005 00400000
R 00400abc 0 00000abc 0 1 0 0 0
R 00601024 0 22222024 1 0 0 0 0
R 10012345 0 40012345 0 0 0 0 0
I 04 005 00000000
R 00601024 0 00000024 0 1 0 0 0
R 00a00020 0 44444020 3 0 0 0 0
C 018 00000009
R 00700100 0 33333100 1 0 0 0 0
I 02 000 00000000
R 10012345 0 00000345 0 1 0 0 0
R 00a00020 0 00000020 0 1 0 0 0
R 00700100 0 33333100 1 0 0 0 0
# write and request in one cycle, then back to back
T 5 00580 0c 0 009 1 55555 0 1 1 1 56789 0 2 1 1
+ R 00b00040 0 00000040 0 1 0 0 0
R 00b00040 0 55555040 1 0 0 0 0
R 00b01040 1 56789040 2 0 0 0 0
N

// File: filelist.f
+incdir+.
mmu_pkg.sv
tlb_search_if.sv
tlb_write_if.sv
mmu_csr.sv
tlb.sv
addr_trans.sv
mmu_top.sv
tb_mmu.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat filelist.f)) mmu_config.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_mmu: $(SRCS) filelist.f
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mmu -f filelist.f -o Vtb_mmu

run: obj_dir/Vtb_mmu
	obj_dir/Vtb_mmu

clean:
	rm -rf obj_dir
